// File: source/memPkg.sv
/*
 * Widths, word, line and address types, request and RAM port structs
 * shared by the scratchpad memory.
 */
`default_nettype none

package memPkg;

    localparam int addrWidth = 32;
    localparam int wordBytes = 4;
    localparam int lineBytes = 32;

    typedef logic [wordBytes*8-1:0] word_t;
    typedef logic [lineBytes*8-1:0] line_t;
    typedef logic [addrWidth-1:0]   addr_t;

    typedef enum logic {
        lsLoad,
        lsStore
    } lsOp_t;

    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } lsSize_t;

    // narrow side request.
    typedef struct packed {
        logic    valid;
        lsOp_t   op;
        lsSize_t size;
        logic    isSigned;
        addr_t   addr;
        word_t   data;
    } lsReq_t;

    typedef enum logic [1:0] {
        lineWrite,
        lineRead,
        lineCopy
    } lineOp_t;

    // addr is the destination for write and copy, the source for read.
    typedef struct packed {
        logic    valid;
        lineOp_t op;
        addr_t   addr;
        addr_t   srcAddr;
        line_t   data;
    } lineReq_t;

    typedef struct packed {
        logic  wrEn;
        addr_t wrAddr;
        word_t wrData;
        logic  rdEn;
        addr_t rdAddr;
    } narrowPort_t;

    typedef struct packed {
        logic  wrEn;
        addr_t wrAddr;
        line_t wrData;
        logic  rdEn;
        addr_t rdAddr;
    } widePort_t;

endpackage

`default_nettype wire

// File: source/ram2w2r.sv
/*
 * Byte RAM with a word port and a line port, registered reads,
 * lowest address in the most significant byte.
 */
`timescale 1ns/1ps
`default_nettype none

module ram2w2r #(
    parameter int depth = 1024
) (
    input  wire logic                clk,
    input  wire logic                nrst,
    input  wire memPkg::narrowPort_t narrow_i,
    output memPkg::word_t            narrowRdData_o,
    input  wire memPkg::widePort_t   wide_i,
    output memPkg::line_t            wideRdData_o
);

    localparam int idxWidth = $clog2(depth);
    localparam memPkg::addr_t lastNarrow = memPkg::addr_t'(depth - memPkg::wordBytes);
    localparam memPkg::addr_t lastWide   = memPkg::addr_t'(depth - memPkg::lineBytes);

    logic [7:0] mem [depth];

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= 8'h00;
            end
            narrowRdData_o <= '0;
            wideRdData_o   <= '0;
        end else begin
            if (narrow_i.wrEn) begin
                for (int i = 0; i < memPkg::wordBytes; i++) begin
                    mem[idxWidth'(narrow_i.wrAddr + memPkg::addr_t'(i))] <=
                        narrow_i.wrData[(memPkg::wordBytes-1-i)*8 +: 8];
                end
            end
            // issued after the narrow write so the line port wins a shared byte.
            if (wide_i.wrEn) begin
                for (int i = 0; i < memPkg::lineBytes; i++) begin
                    mem[idxWidth'(wide_i.wrAddr + memPkg::addr_t'(i))] <=
                        wide_i.wrData[(memPkg::lineBytes-1-i)*8 +: 8];
                end
            end
            if (narrow_i.rdEn) begin
                for (int i = 0; i < memPkg::wordBytes; i++) begin
                    narrowRdData_o[(memPkg::wordBytes-1-i)*8 +: 8] <=
                        mem[idxWidth'(narrow_i.rdAddr + memPkg::addr_t'(i))];
                end
            end
            if (wide_i.rdEn) begin
                for (int i = 0; i < memPkg::lineBytes; i++) begin
                    wideRdData_o[(memPkg::lineBytes-1-i)*8 +: 8] <=
                        mem[idxWidth'(wide_i.rdAddr + memPkg::addr_t'(i))];
                end
            end
        end
    end

    // every enabled access fits inside the array.
    narrowInRange: assert property (@(posedge clk) disable iff (!nrst)
        (!narrow_i.wrEn || narrow_i.wrAddr <= lastNarrow) &&
        (!narrow_i.rdEn || narrow_i.rdAddr <= lastNarrow))
        else $error("narrow port access outside the RAM");

    wideInRange: assert property (@(posedge clk) disable iff (!nrst)
        (!wide_i.wrEn || wide_i.wrAddr <= lastWide) &&
        (!wide_i.rdEn || wide_i.rdAddr <= lastWide))
        else $error("line port access outside the RAM");

endmodule

`default_nettype wire

// File: source/loadStoreUnit.sv
/*
 * Load/store unit: sized loads with sign or zero extension,
 * sub-word stores by read-modify-write on the narrow port.
 */
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit #(
    parameter int depth = 1024
) (
    input  wire logic                clk,
    input  wire logic                nrst,
    input  wire memPkg::lsReq_t      req_i,
    output memPkg::narrowPort_t      port_o,
    input  wire memPkg::word_t       rdData_i,
    output memPkg::word_t            loadData_o,
    output logic                     loadValid_o,
    output logic                     storeDone_o,
    output logic                     busy_o
);

    logic            busy;
    logic            accept;
    logic            isLoad;
    logic            isWordStore;
    logic            isSubStore;
    memPkg::addr_t   wordAddr;
    logic [4:0]      byteShift;
    memPkg::word_t   storeMask;
    memPkg::word_t   storeBits;
    memPkg::addr_t   heldAddr;
    memPkg::word_t   heldMask;
    memPkg::word_t   heldBits;
    logic [1:0]      ldOffset;
    memPkg::lsSize_t ldSize;
    logic            ldSigned;
    memPkg::word_t   ldShifted;

    assign accept      = req_i.valid && !busy;
    assign isLoad      = accept && req_i.op == memPkg::lsLoad;
    assign isWordStore = accept && req_i.op == memPkg::lsStore &&
                         req_i.size == memPkg::sizeWord;
    assign isSubStore  = accept && req_i.op == memPkg::lsStore &&
                         req_i.size != memPkg::sizeWord;

    assign wordAddr  = {req_i.addr[memPkg::addrWidth-1:2], 2'b00};
    assign byteShift = {req_i.addr[1:0], 3'b000};

    // offset 0 is the top byte, so new bytes shift down from the msb.
    always_comb begin
        if (req_i.size == memPkg::sizeByte) begin
            storeMask = 32'hFF00_0000 >> byteShift;
            storeBits = {req_i.data[7:0], 24'h00_0000} >> byteShift;
        end else begin
            storeMask = 32'hFFFF_0000 >> byteShift;
            storeBits = {req_i.data[15:0], 16'h0000} >> byteShift;
        end
    end

    always_comb begin
        port_o = '0;
        if (busy) begin
            // second half of a sub-word store.
            port_o.wrEn   = 1'b1;
            port_o.wrAddr = heldAddr;
            port_o.wrData = (rdData_i & ~heldMask) | heldBits;
        end else if (isLoad || isSubStore) begin
            port_o.rdEn   = 1'b1;
            port_o.rdAddr = wordAddr;
        end else if (isWordStore) begin
            port_o.wrEn   = 1'b1;
            port_o.wrAddr = wordAddr;
            port_o.wrData = req_i.data;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            busy        <= 1'b0;
            loadValid_o <= 1'b0;
            storeDone_o <= 1'b0;
        end else begin
            busy        <= isSubStore;
            loadValid_o <= isLoad;
            storeDone_o <= isWordStore || busy;
        end
    end

    always_ff @(posedge clk) begin
        if (isSubStore) begin
            heldAddr <= wordAddr;
            heldMask <= storeMask;
            heldBits <= storeBits & storeMask;
        end
        if (isLoad) begin
            ldOffset <= req_i.addr[1:0];
            ldSize   <= req_i.size;
            ldSigned <= req_i.isSigned;
        end
    end

    // bring the addressed bytes to the top, then extend downwards.
    assign ldShifted = rdData_i << {ldOffset, 3'b000};

    always_comb begin
        case (ldSize)
            memPkg::sizeByte:
                loadData_o = {{24{ldSigned && ldShifted[31]}}, ldShifted[31:24]};
            memPkg::sizeHalf:
                loadData_o = {{16{ldSigned && ldShifted[31]}}, ldShifted[31:16]};
            default:
                loadData_o = rdData_i;
        endcase
    end

    assign busy_o = busy;

    halfAligned: assert property (@(posedge clk) disable iff (!nrst)
        req_i.valid && req_i.size == memPkg::sizeHalf |-> !req_i.addr[0])
        else $error("halfword access not 2-aligned");

    wordAligned: assert property (@(posedge clk) disable iff (!nrst)
        req_i.valid && req_i.size == memPkg::sizeWord |-> req_i.addr[1:0] == 2'b00)
        else $error("word access not 4-aligned");

    addrInRange: assert property (@(posedge clk) disable iff (!nrst)
        req_i.valid |-> req_i.addr < memPkg::addr_t'(depth))
        else $error("narrow request outside the RAM");

    // a read-modify-write owns the port for its second cycle.
    noReqWhileBusy: assert property (@(posedge clk) disable iff (!nrst)
        busy |-> !req_i.valid)
        else $error("narrow request while busy");

endmodule

`default_nettype wire

// File: source/lineMover.sv
/*
 * Line mover: line write, line read and line copy on the wide port.
 */
`timescale 1ns/1ps
`default_nettype none

module lineMover #(
    parameter int depth = 1024
) (
    input  wire logic              clk,
    input  wire logic              nrst,
    input  wire memPkg::lineReq_t  req_i,
    output memPkg::widePort_t      port_o,
    input  wire memPkg::line_t     rdData_i,
    output memPkg::line_t          lineData_o,
    output logic                   lineValid_o,
    output logic                   lineDone_o,
    output logic                   busy_o
);

    logic          busy;
    logic          accept;
    logic          isWrite;
    logic          isRead;
    logic          isCopy;
    memPkg::addr_t dstAddr;

    assign accept  = req_i.valid && !busy;
    assign isWrite = accept && req_i.op == memPkg::lineWrite;
    assign isRead  = accept && req_i.op == memPkg::lineRead;
    assign isCopy  = accept && req_i.op == memPkg::lineCopy;

    always_comb begin
        port_o = '0;
        if (busy) begin
            // copy write-back of the line read last cycle.
            port_o.wrEn   = 1'b1;
            port_o.wrAddr = dstAddr;
            port_o.wrData = rdData_i;
        end else if (isWrite) begin
            port_o.wrEn   = 1'b1;
            port_o.wrAddr = req_i.addr;
            port_o.wrData = req_i.data;
        end else if (isRead) begin
            port_o.rdEn   = 1'b1;
            port_o.rdAddr = req_i.addr;
        end else if (isCopy) begin
            port_o.rdEn   = 1'b1;
            port_o.rdAddr = req_i.srcAddr;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            busy        <= 1'b0;
            lineValid_o <= 1'b0;
            lineDone_o  <= 1'b0;
        end else begin
            busy        <= isCopy;
            lineValid_o <= isRead;
            lineDone_o  <= isWrite || busy;
        end
    end

    always_ff @(posedge clk) begin
        if (isCopy) begin
            dstAddr <= req_i.addr;
        end
    end

    // read data holds until the next line read.
    assign lineData_o = rdData_i;
    assign busy_o     = busy;

    lineAligned: assert property (@(posedge clk) disable iff (!nrst)
        req_i.valid |-> req_i.addr[4:0] == 5'd0 &&
        (req_i.op != memPkg::lineCopy || req_i.srcAddr[4:0] == 5'd0))
        else $error("line address not 32-aligned");

    lineInRange: assert property (@(posedge clk) disable iff (!nrst)
        req_i.valid |-> req_i.addr < memPkg::addr_t'(depth) &&
        (req_i.op != memPkg::lineCopy || req_i.srcAddr < memPkg::addr_t'(depth)))
        else $error("line request outside the RAM");

    noReqWhileBusy: assert property (@(posedge clk) disable iff (!nrst)
        busy |-> !req_i.valid)
        else $error("line request while busy");

endmodule

`default_nettype wire

// File: source/memTop.sv
/*
 * Scratchpad top: load/store unit and line mover sharing one RAM.
 */
`timescale 1ns/1ps
`default_nettype none

module memTop #(
    parameter int depth = 1024
) (
    input  wire logic              clk,
    input  wire logic              nrst,
    input  wire memPkg::lsReq_t    lsReq_i,
    input  wire memPkg::lineReq_t  lineReq_i,
    output memPkg::word_t          loadData_o,
    output logic                   loadValid_o,
    output logic                   storeDone_o,
    output logic                   lsBusy_o,
    output memPkg::line_t          lineData_o,
    output logic                   lineValid_o,
    output logic                   lineDone_o,
    output logic                   lineBusy_o
);

    memPkg::narrowPort_t narrowPort;
    memPkg::word_t       narrowRdData;
    memPkg::widePort_t   widePort;
    memPkg::line_t       wideRdData;

    loadStoreUnit #(
        .depth(depth)
    ) lsu_i (
        .clk        (clk),
        .nrst       (nrst),
        .req_i      (lsReq_i),
        .port_o     (narrowPort),
        .rdData_i   (narrowRdData),
        .loadData_o (loadData_o),
        .loadValid_o(loadValid_o),
        .storeDone_o(storeDone_o),
        .busy_o     (lsBusy_o)
    );

    lineMover #(
        .depth(depth)
    ) mover_i (
        .clk        (clk),
        .nrst       (nrst),
        .req_i      (lineReq_i),
        .port_o     (widePort),
        .rdData_i   (wideRdData),
        .lineData_o (lineData_o),
        .lineValid_o(lineValid_o),
        .lineDone_o (lineDone_o),
        .busy_o     (lineBusy_o)
    );

    ram2w2r #(
        .depth(depth)
    ) ram_i (
        .clk           (clk),
        .nrst          (nrst),
        .narrow_i      (narrowPort),
        .narrowRdData_o(narrowRdData),
        .wide_i        (widePort),
        .wideRdData_o  (wideRdData)
    );

endmodule

`default_nettype wire

// File: tests/memTopChecks.svh
/*
 * Compare tasks for word and line results of the scratchpad testbench.
 */
`ifndef MEM_TOP_CHECKS_SVH
`define MEM_TOP_CHECKS_SVH

// word results, also used for latencies and status flags.
task automatic checkWord(
    input string         name,
    input memPkg::word_t got,
    input memPkg::word_t exp
);
    if (got !== exp) begin
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        abortRun();
    end
endtask

task automatic checkLine(
    input string         name,
    input memPkg::line_t got,
    input memPkg::line_t exp
);
    if (got !== exp) begin
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        abortRun();
    end
endtask

`endif

// File: tests/memTopTb.sv
/*
 * Testbench for memTop: clock, reset, LCG, byte reference model,
 * stimulus table applied in a loop, cycle timeout.
 */
`timescale 1ns/1ps
`default_nettype none

module memTopTb;

    localparam int depth = 1024;
    localparam int idxW = $clog2(depth);
    localparam memPkg::lsOp_t   opLd = memPkg::lsLoad;
    localparam memPkg::lsOp_t   opSt = memPkg::lsStore;
    localparam memPkg::lsSize_t szB  = memPkg::sizeByte;
    localparam memPkg::lsSize_t szH  = memPkg::sizeHalf;
    localparam memPkg::lsSize_t szW  = memPkg::sizeWord;
    localparam memPkg::lineOp_t lnWr = memPkg::lineWrite;
    localparam memPkg::lineOp_t lnRd = memPkg::lineRead;
    localparam memPkg::lineOp_t lnCp = memPkg::lineCopy;

    // fixed marks data taken from the table instead of the LCG.
    typedef struct packed {
        logic            valid;
        memPkg::lsOp_t   op;
        memPkg::lsSize_t size;
        logic            isSigned;
        logic [idxW-1:0] addr;
        logic            fixed;
        memPkg::word_t   data;
    } lsStep_t;

    typedef struct packed {
        logic            valid;
        memPkg::lineOp_t op;
        logic [idxW-1:0] addr;
        logic [idxW-1:0] src;
    } lnStep_t;

    typedef struct packed {
        lsStep_t ls;
        lnStep_t ln;
    } step_t;

    localparam lsStep_t lsIdle = '0;
    localparam lnStep_t lnIdle = '0;
    localparam int nSteps = 26;
    localparam int timeoutCycles = nSteps * 6 + 50;

    step_t steps [nSteps] = '{
        '{'{1'b1, opLd, szW, 1'b0, 10'h000, 1'b0, 32'h0}, '{1'b1, lnRd, 10'h000, 10'h000}},
        '{'{1'b1, opLd, szW, 1'b0, 10'h3FC, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opSt, szW, 1'b0, 10'h040, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h040, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opSt, szB, 1'b0, 10'h045, 1'b1, 32'h9C}, lnIdle},
        '{'{1'b1, opSt, szH, 1'b0, 10'h046, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h044, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szB, 1'b1, 10'h045, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szB, 1'b0, 10'h045, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szH, 1'b1, 10'h046, 1'b0, 32'h0}, lnIdle},
        '{lsIdle, '{1'b1, lnWr, 10'h080, 10'h000}},
        '{'{1'b1, opLd, szW, 1'b0, 10'h080, 1'b0, 32'h0}, '{1'b1, lnRd, 10'h040, 10'h000}},
        '{'{1'b1, opLd, szW, 1'b0, 10'h084, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h088, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h08C, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h090, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h094, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h098, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opLd, szW, 1'b0, 10'h09C, 1'b0, 32'h0}, lnIdle},
        '{'{1'b1, opSt, szB, 1'b0, 10'h203, 1'b0, 32'h0}, '{1'b1, lnCp, 10'h100, 10'h080}},
        '{'{1'b1, opLd, szW, 1'b0, 10'h200, 1'b0, 32'h0}, '{1'b1, lnRd, 10'h100, 10'h000}},
        '{lsIdle, '{1'b1, lnRd, 10'h080, 10'h000}},
        // same-cycle collision on 0x0C4..0x0C7.
        '{'{1'b1, opSt, szW, 1'b0, 10'h0C4, 1'b0, 32'h0}, '{1'b1, lnWr, 10'h0C0, 10'h000}},
        '{'{1'b1, opLd, szW, 1'b0, 10'h0C4, 1'b0, 32'h0}, '{1'b1, lnRd, 10'h0C0, 10'h000}},
        '{'{1'b1, opSt, szH, 1'b0, 10'h0E2, 1'b0, 32'h0}, '{1'b1, lnCp, 10'h1E0, 10'h0C0}},
        '{'{1'b1, opLd, szH, 1'b0, 10'h0E2, 1'b0, 32'h0}, '{1'b1, lnRd, 10'h1E0, 10'h000}}
    };

    logic             clk;
    logic             nrst;
    memPkg::lsReq_t   lsReq;
    memPkg::lineReq_t lineReq;
    memPkg::word_t    loadData;
    logic             loadValid;
    logic             storeDone;
    logic             lsBusy;
    memPkg::line_t    lineData;
    logic             lineValid;
    logic             lineDone;
    logic             lineBusy;
    logic [7:0]       model [depth];
    logic [31:0]      lcgState;
    int               cycles = 0;

    memTop #(
        .depth(depth)
    ) dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .lsReq_i    (lsReq),
        .lineReq_i  (lineReq),
        .loadData_o (loadData),
        .loadValid_o(loadValid),
        .storeDone_o(storeDone),
        .lsBusy_o   (lsBusy),
        .lineData_o (lineData),
        .lineValid_o(lineValid),
        .lineDone_o (lineDone),
        .lineBusy_o (lineBusy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    `include "memTopChecks.svh"

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic memPkg::line_t randomLine();
        memPkg::line_t l;
        for (int i = 0; i < 8; i++) begin
            l[32*i +: 32] = nextRandom();
        end
        return l;
    endfunction

    // lowest address lands in the most significant byte.
    function automatic memPkg::line_t readLine(input logic [idxW-1:0] a);
        memPkg::line_t l;
        for (int i = 0; i < 32; i++) begin
            l[255-8*i -: 8] = model[a + idxW'(i)];
        end
        return l;
    endfunction

    function automatic void writeLine(input logic [idxW-1:0] a, input memPkg::line_t l);
        for (int i = 0; i < 32; i++) begin
            model[a + idxW'(i)] = l[255-8*i -: 8];
        end
    endfunction

    function automatic void storeNarrow(
        input logic [idxW-1:0] a,
        input memPkg::lsSize_t size,
        input memPkg::word_t   d
    );
        if (size == szB) begin
            model[a] = d[7:0];
        end else if (size == szH) begin
            model[a] = d[15:8];
            model[a + idxW'(1)] = d[7:0];
        end else begin
            for (int i = 0; i < 4; i++) begin
                model[a + idxW'(i)] = d[31-8*i -: 8];
            end
        end
    endfunction

    function automatic memPkg::word_t expectLoad(
        input logic [idxW-1:0] a,
        input memPkg::lsSize_t size,
        input logic            sgn
    );
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = model[a];
        b1 = model[a + idxW'(1)];
        if (size == szB) begin
            return {{24{sgn & b0[7]}}, b0};
        end else if (size == szH) begin
            return {{16{sgn & b0[7]}}, b0, b1};
        end
        return {b0, b1, model[a + idxW'(2)], model[a + idxW'(3)]};
    endfunction

    task automatic runStep(input step_t s);
        memPkg::lsReq_t   lr;
        memPkg::lineReq_t nr;
        memPkg::word_t    expWord;
        memPkg::line_t    expLine;
        memPkg::word_t    gotWord;
        memPkg::line_t    gotLine;
        int               lsLat;
        int               lnLat;
        int               lsSeen;
        int               lnSeen;
        int               waited;
        lr = '0;
        lr.valid    = s.ls.valid;
        lr.op       = s.ls.op;
        lr.size     = s.ls.size;
        lr.isSigned = s.ls.isSigned;
        lr.addr     = memPkg::addr_t'(s.ls.addr);
        lr.data     = s.ls.fixed ? s.ls.data : nextRandom();
        nr = '0;
        nr.valid   = s.ln.valid;
        nr.op      = s.ln.op;
        nr.addr    = memPkg::addr_t'(s.ln.addr);
        nr.srcAddr = memPkg::addr_t'(s.ln.src);
        nr.data    = (s.ln.op == lnWr) ? randomLine() : '0;
        // reads see memory as it was before this entry's writes.
        expWord = expectLoad(s.ls.addr, s.ls.size, s.ls.isSigned);
        expLine = readLine(s.ln.op == lnRd ? s.ln.addr : s.ln.src);
        lsLat = (s.ls.op == opSt && s.ls.size != szW) ? 2 : 1;
        lnLat = (s.ln.op == lnCp) ? 2 : 1;
        if (s.ls.valid && s.ls.op == opSt) begin
            storeNarrow(s.ls.addr, s.ls.size, lr.data);
        end
        // line writes land after narrow writes of the same cycle.
        if (s.ln.valid && s.ln.op == lnWr) begin
            writeLine(s.ln.addr, nr.data);
        end else if (s.ln.valid && s.ln.op == lnCp) begin
            writeLine(s.ln.addr, expLine);
        end
        @(posedge clk);
        lsReq   <= lr;
        lineReq <= nr;
        @(posedge clk);
        lsReq   <= '0;
        lineReq <= '0;
        lsSeen = 0;
        lnSeen = 0;
        waited = 0;
        gotWord = '0;
        gotLine = '0;
        while (waited < 4 && ((s.ls.valid && lsSeen == 0) || (s.ln.valid && lnSeen == 0))) begin
            @(negedge clk);
            waited++;
            // two-cycle operations hold busy in their second cycle.
            if (waited == 1) begin
                checkWord("lsBusy_o", memPkg::word_t'(lsBusy),
                    memPkg::word_t'(s.ls.valid && lsLat == 2));
                checkWord("lineBusy_o", memPkg::word_t'(lineBusy),
                    memPkg::word_t'(s.ln.valid && lnLat == 2));
            end
            if (lsSeen == 0 && (s.ls.op == opLd ? loadValid : storeDone)) begin
                lsSeen  = waited;
                gotWord = loadData;
            end
            if (lnSeen == 0 && (s.ln.op == lnRd ? lineValid : lineDone)) begin
                lnSeen  = waited;
                gotLine = lineData;
            end
        end
        if (s.ls.valid) begin
            if (lsSeen == 0) begin
                $display("no narrow-side done or valid pulse within 4 cycles");
                abortRun();
            end
            checkWord("loadValid_o/storeDone_o latency",
                memPkg::word_t'(lsSeen), memPkg::word_t'(lsLat));
            if (s.ls.op == opLd) begin
                checkWord("loadData_o", gotWord, expWord);
            end
        end
        if (s.ln.valid) begin
            if (lnSeen == 0) begin
                $display("no line-side done or valid pulse within 4 cycles");
                abortRun();
            end
            checkWord("lineValid_o/lineDone_o latency",
                memPkg::word_t'(lnSeen), memPkg::word_t'(lnLat));
            if (s.ln.op == lnRd) begin
                checkLine("lineData_o", gotLine, expLine);
            end
        end
        while (lsBusy || lineBusy) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("run did not finish within %0d cycles", timeoutCycles);
            abortRun();
        end
    end

    initial begin
        nrst     = 1'b0;
        lsReq    = '0;
        lineReq  = '0;
        lcgState = 32'h8668_0293;
        for (int i = 0; i < depth; i++) begin
            model[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        checkWord("status outputs after reset",
            memPkg::word_t'({loadValid, storeDone, lsBusy, lineValid, lineDone, lineBusy}),
            '0);
        for (int i = 0; i < nSteps; i++) begin
            runStep(steps[i]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+tests
source/memPkg.sv
source/ram2w2r.sv
source/loadStoreUnit.sv
source/lineMover.sv
source/memTop.sv
tests/memTopTb.sv

// File: run.sh
#!/bin/sh
# Build and run the scratchpad testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module memTopTb -f list.f \
    --Mdir obj_dir -o simv > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1

grep -q "Test failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; } ||
    grep -q "Test passed" sim.log && { echo "simulation passed"; exit 0; } ||
    { echo "simulation ended without a result, see sim.log"; exit 1; }
